//--- Makefile
SIM_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f project.f \
		--top-module tb_exec_stage -Mdir $(SIM_DIR) -o sim_exec_stage

run: compile
	./$(SIM_DIR)/sim_exec_stage | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(SIM_DIR) sim.log

//--- design/exec_alu.sv
module exec_alu (
	input exec_pkg::word_t i_op1,
	input exec_pkg::word_t i_op2,
	input exec_pkg::alu_opc_t i_opc,
	input logic i_carry_in,
	input exec_pkg::word_t i_cr_val,
	input exec_pkg::vector_base_t i_vector_base,
	input exec_pkg::word_t i_fault_address,
	output exec_pkg::word_t o_result,
	output logic o_carry,
	output logic o_zero,
	output logic o_neg,
	output logic o_ovf
);

	logic [exec_pkg::WORD_W:0] wide; // Carry out on top
	logic [exec_pkg::WORD_W:0] a_ext;
	logic [exec_pkg::WORD_W:0] b_ext;
	logic [exec_pkg::WORD_W:0] c_ext;
	logic [exec_pkg::SHAMT_W-1:0] shamt;
	exec_pkg::word_t bit_mask;
	exec_pkg::word_t vector_addr;

	assign a_ext = {1'b0, i_op1};
	assign b_ext = {1'b0, i_op2};
	assign c_ext = {{exec_pkg::WORD_W{1'b0}}, i_carry_in};
	assign shamt = i_op2[exec_pkg::SHAMT_W-1:0];
	assign bit_mask = exec_pkg::word_t'(1) << shamt;
	assign vector_addr = {i_vector_base, {exec_pkg::VECTOR_LSB{1'b0}}};

	// Equality compare, independent of opcode
	assign o_zero = (i_op1 == i_op2);

	always_comb begin
		wide = '0;
		o_neg = 1'b0;
		o_ovf = 1'b0;

		case (i_opc)
		exec_pkg::ALU_OPC_ADD: wide = a_ext + b_ext;
		exec_pkg::ALU_OPC_ADDC: wide = a_ext + b_ext + c_ext;
		exec_pkg::ALU_OPC_SUB: wide = a_ext - b_ext;
		exec_pkg::ALU_OPC_SUBC: wide = a_ext - b_ext - c_ext;
		exec_pkg::ALU_OPC_MUL: wide = a_ext * b_ext; // Bit 32 of product is carry
		exec_pkg::ALU_OPC_LSL: wide = a_ext << shamt;
		exec_pkg::ALU_OPC_LSR: wide = {1'b0, i_op1 >> shamt};
		exec_pkg::ALU_OPC_AND: wide = {1'b0, i_op1 & i_op2};
		exec_pkg::ALU_OPC_XOR: wide = {1'b0, i_op1 ^ i_op2};
		exec_pkg::ALU_OPC_BIC: wide = {1'b0, i_op1 & ~bit_mask};
		exec_pkg::ALU_OPC_BST: wide = {1'b0, i_op1 | bit_mask};
		exec_pkg::ALU_OPC_OR: wide = {1'b0, i_op1 | i_op2};
		exec_pkg::ALU_OPC_COPYB: wide = b_ext;
		exec_pkg::ALU_OPC_CMP: begin
			wide = a_ext - b_ext;
			o_neg = wide[exec_pkg::WORD_W-1];
			// Signed overflow of op1 - op2
			o_ovf = (i_op1[exec_pkg::WORD_W-1] ^ i_op2[exec_pkg::WORD_W-1]) &&
				(wide[exec_pkg::WORD_W-1] == i_op2[exec_pkg::WORD_W-1]);
		end
		exec_pkg::ALU_OPC_MOVHI: wide = {1'b0, i_op1 | {16'b0, i_op2[15:0]}};
		exec_pkg::ALU_OPC_ASR: begin
			wide = {1'b0, exec_pkg::word_t'($signed(i_op1) >>> shamt)};
		end
		exec_pkg::ALU_OPC_COPYA: wide = a_ext;
		exec_pkg::ALU_OPC_GCR: wide = {1'b0, i_cr_val};
		exec_pkg::ALU_OPC_SWI: wide = {1'b0, vector_addr + exec_pkg::SWI_VECTOR_OFFSET};
		exec_pkg::ALU_OPC_RFE: wide = {1'b0, i_fault_address}; // Return address
		default: wide = '0;
		endcase
	end

	assign o_result = wide[exec_pkg::WORD_W-1:0];
	assign o_carry = wide[exec_pkg::WORD_W];

endmodule

//--- design/exec_ctrl_regs.sv
module exec_ctrl_regs (
	input logic clk,
	input logic rst,
	input exec_pkg::word_t i_wr_val,
	input exec_pkg::cr_sel_t i_cr_sel,
	input logic i_write_cr,
	input logic i_alu_zero,
	input logic i_alu_neg,
	input logic i_alu_ovf,
	input logic i_alu_carry,
	input logic i_update_flags,
	input logic i_update_carry,
	input logic i_is_swi,
	input logic i_is_rfe,
	input logic i_exception_start,
	input logic i_irq_start,
	input exec_pkg::word_t i_irq_fault_address,
	input exec_pkg::word_t i_pc_plus_4,
	input logic i_data_abort,
	input exec_pkg::word_t i_mar,
	input exec_pkg::cr_sel_t i_dbg_cr_sel,
	input exec_pkg::word_t i_dbg_cr_wr_val,
	input logic i_dbg_cr_wr_en,
	output exec_pkg::psr_t o_psr,
	output exec_pkg::word_t o_cr_val,
	output exec_pkg::word_t o_dbg_cr_val,
	output exec_pkg::vector_base_t o_vector_base,
	output exec_pkg::word_t o_fault_address
);

	exec_pkg::vector_base_t vector_addr;
	exec_pkg::psr_t psr_q;
	exec_pkg::psr_t saved_psr;
	exec_pkg::word_t fault_address;
	exec_pkg::word_t data_fault_address;

	logic [exec_pkg::NUM_CR-1:0] dbg_wr; // One-hot write strobes
	logic [exec_pkg::NUM_CR-1:0] cpu_wr;
	exec_pkg::word_t cr_file [exec_pkg::NUM_CR];

	always_comb begin
		dbg_wr = '0;
		cpu_wr = '0;
		dbg_wr[i_dbg_cr_sel] = i_dbg_cr_wr_en;
		cpu_wr[i_cr_sel] = i_write_cr;
	end

	// ********************
	// Read side
	// ********************
	always_comb begin
		for (int i = 0; i < exec_pkg::NUM_CR; i++)
			cr_file[i] = '0;
		cr_file[exec_pkg::CR_VECTOR] = {vector_addr, {exec_pkg::VECTOR_LSB{1'b0}}};
		cr_file[exec_pkg::CR_PSR] = {{(exec_pkg::WORD_W-exec_pkg::PSR_W){1'b0}}, psr_q};
		cr_file[exec_pkg::CR_SAVED_PSR] =
			{{(exec_pkg::WORD_W-exec_pkg::PSR_W){1'b0}}, saved_psr};
		cr_file[exec_pkg::CR_FAULT] = fault_address;
		cr_file[exec_pkg::CR_DATA_FAULT] = data_fault_address;
	end

	assign o_cr_val = cr_file[i_cr_sel];
	assign o_dbg_cr_val = cr_file[i_dbg_cr_sel];
	assign o_psr = psr_q;
	assign o_vector_base = vector_addr;
	assign o_fault_address = fault_address;

	// ********************
	// Write side
	// ********************
	always_ff @(posedge clk) begin
		if (rst)
			vector_addr <= '0;
		else if (dbg_wr[exec_pkg::CR_VECTOR])
			vector_addr <= i_dbg_cr_wr_val[exec_pkg::WORD_W-1:exec_pkg::VECTOR_LSB];
		else if (cpu_wr[exec_pkg::CR_VECTOR])
			vector_addr <= i_wr_val[exec_pkg::WORD_W-1:exec_pkg::VECTOR_LSB];
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= '0;
		else if (dbg_wr[exec_pkg::CR_SAVED_PSR])
			saved_psr <= i_dbg_cr_wr_val[exec_pkg::PSR_W-1:0];
		else if (i_is_swi || i_exception_start || i_irq_start)
			saved_psr <= psr_q; // Snapshot on any entry
		else if (cpu_wr[exec_pkg::CR_SAVED_PSR])
			saved_psr <= i_wr_val[exec_pkg::PSR_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_address <= '0;
		else if (dbg_wr[exec_pkg::CR_FAULT])
			fault_address <= i_dbg_cr_wr_val;
		else if (i_irq_start)
			fault_address <= i_irq_fault_address;
		else if (i_exception_start)
			fault_address <= i_pc_plus_4;
		else if (cpu_wr[exec_pkg::CR_FAULT])
			fault_address <= i_wr_val;
	end

	always_ff @(posedge clk) begin
		if (rst)
			data_fault_address <= '0;
		else if (dbg_wr[exec_pkg::CR_DATA_FAULT])
			data_fault_address <= i_dbg_cr_wr_val;
		else if (i_data_abort)
			data_fault_address <= i_mar;
		else if (cpu_wr[exec_pkg::CR_DATA_FAULT])
			data_fault_address <= i_wr_val;
	end

	// PSR: later assignments take priority
	always_ff @(posedge clk) begin
		if (rst) begin
			psr_q <= '0;
		end else begin
			if (i_update_flags) begin
				psr_q[exec_pkg::PSR_Z] <= i_alu_zero;
				psr_q[exec_pkg::PSR_N] <= i_alu_neg;
				psr_q[exec_pkg::PSR_O] <= i_alu_ovf;
			end
			if (i_update_carry)
				psr_q[exec_pkg::PSR_C] <= i_alu_carry;
			if (i_exception_start)
				psr_q[exec_pkg::PSR_IRQ] <= 1'b0;
			if (i_is_rfe)
				psr_q <= saved_psr;
			if (dbg_wr[exec_pkg::CR_PSR])
				psr_q <= i_dbg_cr_wr_val[exec_pkg::PSR_W-1:0];
			if (cpu_wr[exec_pkg::CR_PSR])
				psr_q <= i_wr_val[exec_pkg::PSR_W-1:0];
		end
	end

	// Return and entry in one cycle would lose the saved PSR
	a_rfe_not_in_entry: assert property (@(posedge clk) disable iff (rst)
		!(i_is_rfe && i_exception_start))
		else $error("RFE and exception start asserted together");

endmodule

//--- design/exec_pkg.sv
package exec_pkg;

	// ********************
	// Widths
	// ********************
	localparam int WORD_W = 32;
	localparam int SHAMT_W = $clog2(WORD_W);
	localparam int VECTOR_LSB = 6; // Vector table is 64-byte aligned
	localparam int PSR_W = 5;
	localparam int NUM_CR = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [3:0] rd_sel_t;
	typedef logic [4:0] alu_opc_t;
	typedef logic [3:0] branch_cc_t;
	typedef logic [1:0] instr_class_t;
	typedef logic [1:0] mem_width_t;
	typedef logic [$clog2(NUM_CR)-1:0] cr_sel_t;
	typedef logic [PSR_W-1:0] psr_t;
	typedef logic [WORD_W-VECTOR_LSB-1:0] vector_base_t;

	// PSR bit positions
	localparam int PSR_IRQ = 4;
	localparam int PSR_N = 3;
	localparam int PSR_O = 2;
	localparam int PSR_C = 1;
	localparam int PSR_Z = 0;

	// ********************
	// ALU opcodes
	// ********************
	localparam alu_opc_t ALU_OPC_ADD = 5'd0;
	localparam alu_opc_t ALU_OPC_ADDC = 5'd1;
	localparam alu_opc_t ALU_OPC_SUB = 5'd2;
	localparam alu_opc_t ALU_OPC_SUBC = 5'd3;
	localparam alu_opc_t ALU_OPC_MUL = 5'd4;
	localparam alu_opc_t ALU_OPC_LSL = 5'd5;
	localparam alu_opc_t ALU_OPC_LSR = 5'd6;
	localparam alu_opc_t ALU_OPC_AND = 5'd7;
	localparam alu_opc_t ALU_OPC_XOR = 5'd8;
	localparam alu_opc_t ALU_OPC_BIC = 5'd9;
	localparam alu_opc_t ALU_OPC_BST = 5'd10;
	localparam alu_opc_t ALU_OPC_OR = 5'd11;
	localparam alu_opc_t ALU_OPC_COPYB = 5'd12;
	localparam alu_opc_t ALU_OPC_CMP = 5'd13;
	localparam alu_opc_t ALU_OPC_MOVHI = 5'd14;
	localparam alu_opc_t ALU_OPC_ASR = 5'd15;
	localparam alu_opc_t ALU_OPC_COPYA = 5'd16;
	localparam alu_opc_t ALU_OPC_GCR = 5'd17;
	localparam alu_opc_t ALU_OPC_SWI = 5'd18;
	localparam alu_opc_t ALU_OPC_RFE = 5'd19;

	// ********************
	// Branch conditions
	// ********************
	localparam branch_cc_t BRANCH_CC_NE = 4'b0001;
	localparam branch_cc_t BRANCH_CC_EQ = 4'b0010;
	localparam branch_cc_t BRANCH_CC_GT = 4'b0011;
	localparam branch_cc_t BRANCH_CC_LT = 4'b0100;
	localparam branch_cc_t BRANCH_CC_GTS = 4'b0101;
	localparam branch_cc_t BRANCH_CC_LTS = 4'b0110;
	localparam branch_cc_t BRANCH_CC_B = 4'b0111;
	localparam branch_cc_t BRANCH_CC_GTE = 4'b1000;
	localparam branch_cc_t BRANCH_CC_GTES = 4'b1001;
	localparam branch_cc_t BRANCH_CC_LTE = 4'b1010;
	localparam branch_cc_t BRANCH_CC_LTES = 4'b1011;

	localparam instr_class_t CLASS_BRANCH = 2'b01;

	// Control register map
	localparam cr_sel_t CR_VECTOR = 3'd0;
	localparam cr_sel_t CR_PSR = 3'd1;
	localparam cr_sel_t CR_SAVED_PSR = 3'd2;
	localparam cr_sel_t CR_FAULT = 3'd3;
	localparam cr_sel_t CR_DATA_FAULT = 3'd4;

	localparam word_t SWI_VECTOR_OFFSET = 32'd8;

endpackage

//--- design/exec_stage.sv
module exec_stage (
	input logic clk,
	input logic rst,
	input exec_pkg::word_t i_ra,
	input exec_pkg::word_t i_rb,
	input exec_pkg::word_t i_imm32,
	input exec_pkg::word_t i_pc_plus_4,
	input exec_pkg::rd_sel_t i_rd_sel,
	input logic i_update_rd,
	input exec_pkg::alu_opc_t i_alu_opc,
	input logic i_alu_op1_ra,
	input logic i_alu_op1_rb,
	input logic i_alu_op2_rb,
	input logic i_mem_load,
	input logic i_mem_store,
	input exec_pkg::mem_width_t i_mem_width,
	input exec_pkg::branch_cc_t i_branch_cc,
	input exec_pkg::instr_class_t i_instr_class,
	input logic i_is_call,
	input logic i_update_carry,
	input logic i_update_flags,
	input exec_pkg::cr_sel_t i_cr_sel,
	input logic i_write_cr,
	input logic i_is_swi,
	input logic i_is_rfe,
	input logic i_data_abort,
	input logic i_exception_start,
	input logic i_irq_start,
	input exec_pkg::word_t i_irq_fault_address,
	input logic i_valid,
	input exec_pkg::cr_sel_t i_dbg_cr_sel,
	input exec_pkg::word_t i_dbg_cr_wr_val,
	input logic i_dbg_cr_wr_en,
	output logic o_branch_taken,
	output exec_pkg::word_t o_alu_out,
	output logic o_mem_load,
	output logic o_mem_store,
	output exec_pkg::mem_width_t o_mem_width,
	output exec_pkg::word_t o_wr_val,
	output logic o_wr_result,
	output exec_pkg::rd_sel_t o_rd_sel,
	output logic o_stall_clear,
	output exec_pkg::word_t o_mar,
	output exec_pkg::word_t o_mdr,
	output logic o_mem_wr_en,
	output logic o_valid,
	output logic o_irqs_enabled,
	output exec_pkg::vector_base_t o_vector_base,
	output exec_pkg::word_t o_dbg_cr_val
);

	exec_pkg::word_t op1;
	exec_pkg::word_t op2;
	exec_pkg::word_t alu_q;
	logic alu_c;
	logic alu_z;
	logic alu_n;
	logic alu_o;
	exec_pkg::psr_t psr;
	exec_pkg::word_t cr_val;
	exec_pkg::word_t fault_address;
	logic cond_met;
	logic z_flag;
	logic c_flag;
	logic n_xor_o; // Signed less-than

	assign op1 = i_alu_op1_ra ? i_ra : i_alu_op1_rb ? i_rb : i_pc_plus_4;
	assign op2 = i_alu_op2_rb ? i_rb : i_imm32;

	exec_alu u_alu (
		.i_op1(op1),
		.i_op2(op2),
		.i_opc(i_alu_opc),
		.i_carry_in(psr[exec_pkg::PSR_C]),
		.i_cr_val(cr_val),
		.i_vector_base(o_vector_base),
		.i_fault_address(fault_address),
		.o_result(alu_q),
		.o_carry(alu_c),
		.o_zero(alu_z),
		.o_neg(alu_n),
		.o_ovf(alu_o)
	);

	exec_ctrl_regs u_ctrl_regs (
		.clk(clk),
		.rst(rst),
		.i_wr_val(i_ra),
		.i_cr_sel(i_cr_sel),
		.i_write_cr(i_write_cr),
		.i_alu_zero(alu_z),
		.i_alu_neg(alu_n),
		.i_alu_ovf(alu_o),
		.i_alu_carry(alu_c),
		.i_update_flags(i_update_flags),
		.i_update_carry(i_update_carry),
		.i_is_swi(i_is_swi),
		.i_is_rfe(i_is_rfe),
		.i_exception_start(i_exception_start),
		.i_irq_start(i_irq_start),
		.i_irq_fault_address(i_irq_fault_address),
		.i_pc_plus_4(i_pc_plus_4),
		.i_data_abort(i_data_abort),
		.i_mar(o_mar),
		.i_dbg_cr_sel(i_dbg_cr_sel),
		.i_dbg_cr_wr_val(i_dbg_cr_wr_val),
		.i_dbg_cr_wr_en(i_dbg_cr_wr_en),
		.o_psr(psr),
		.o_cr_val(cr_val),
		.o_dbg_cr_val(o_dbg_cr_val),
		.o_vector_base(o_vector_base),
		.o_fault_address(fault_address)
	);

	assign o_irqs_enabled = psr[exec_pkg::PSR_IRQ];

	// ********************
	// Branch condition
	// ********************
	assign z_flag = psr[exec_pkg::PSR_Z];
	assign c_flag = psr[exec_pkg::PSR_C];
	assign n_xor_o = psr[exec_pkg::PSR_N] ^ psr[exec_pkg::PSR_O];

	always_comb begin
		case (i_branch_cc)
		exec_pkg::BRANCH_CC_B: cond_met = 1'b1;
		exec_pkg::BRANCH_CC_NE: cond_met = !z_flag;
		exec_pkg::BRANCH_CC_EQ: cond_met = z_flag;
		exec_pkg::BRANCH_CC_GT: cond_met = !c_flag && !z_flag; // Unsigned
		exec_pkg::BRANCH_CC_LT: cond_met = c_flag;
		exec_pkg::BRANCH_CC_GTE: cond_met = !c_flag;
		exec_pkg::BRANCH_CC_LTE: cond_met = c_flag || z_flag;
		exec_pkg::BRANCH_CC_GTS: cond_met = !z_flag && !n_xor_o;
		exec_pkg::BRANCH_CC_LTS: cond_met = n_xor_o;
		exec_pkg::BRANCH_CC_GTES: cond_met = !n_xor_o;
		exec_pkg::BRANCH_CC_LTES: cond_met = n_xor_o || z_flag;
		default: cond_met = 1'b0;
		endcase
	end

	// ********************
	// Stage registers
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			o_branch_taken <= 1'b0;
			o_stall_clear <= 1'b0;
			o_wr_result <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
			o_mem_wr_en <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			o_branch_taken <= (i_instr_class == exec_pkg::CLASS_BRANCH) &&
				(cond_met || i_is_swi || i_is_rfe);
			o_stall_clear <= (i_instr_class == exec_pkg::CLASS_BRANCH);
			o_wr_result <= i_update_rd;
			o_mem_load <= i_mem_load;
			o_mem_store <= i_mem_store;
			o_mem_wr_en <= i_mem_store;
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_alu_out <= '0;
			o_wr_val <= '0;
			o_rd_sel <= '0;
			o_mar <= '0;
			o_mem_width <= '0;
			o_mdr <= '0;
		end else begin
			o_alu_out <= alu_q;
			o_wr_val <= i_is_call ? i_pc_plus_4 : i_mem_store ? op2 : alu_q;
			o_rd_sel <= i_rd_sel;
			if (i_mem_load || i_mem_store) begin
				o_mar <= alu_q; // Effective address
				o_mem_width <= i_mem_width;
			end
			if (i_mem_store)
				o_mdr <= i_rb;
		end
	end

	a_load_store_excl: assert property (@(posedge clk) disable iff (rst)
		!(i_mem_load && i_mem_store))
		else $error("Load and store requested together");

endmodule

//--- dv/exec_vectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// opc, mode, ctl, cc, cr / ra, rb, imm, pc4, alu, wr_val, taken, wr_en, chk dbg, dbg value
task automatic load_vectors();
	// ********************
	// ALU opcodes
	// ********************
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_RB, 0, 0, 0,
		'h10, 'h20, 0, 0, 'h30, 'h30, 0, 0, 1, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, 0, 0, 0,
		'h10, 0, 'h5, 0, 'h15, 'h15, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_SUB, M_RA_RB, 0, 0, 0,
		'h20, 'h30, 0, 0, 'hFFFFFFF0, 'hFFFFFFF0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_SUB, M_RB_RB, 0, 0, 0,
		0, 'h7, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_MUL, M_RA_RB, 0, 0, 0,
		'h10000, 'h300, 0, 0, 'h3000000, 'h3000000, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_LSL, M_RA_IMM, 0, 0, 0,
		'hF1, 0, 'h4, 0, 'hF10, 'hF10, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_LSR, M_RB_IMM, 0, 0, 0,
		0, 'h80000000, 'd31, 0, 'h1, 'h1, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ASR, M_RA_IMM, 0, 0, 0,
		'h80000000, 0, 'h4, 0, 'hF8000000, 'hF8000000, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_AND, M_RA_RB, 0, 0, 0,
		'hF0F0F0F0, 'hFF00FF00, 0, 0, 'hF000F000, 'hF000F000, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_OR, M_RA_IMM, 0, 0, 0,
		'hF0000000, 0, 'hF, 0, 'hF000000F, 'hF000000F, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_XOR, M_RA_RB, 0, 0, 0,
		'hFFFF0000, 'h0F0F0F0F, 0, 0, 'hF0F00F0F, 'hF0F00F0F, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_BIC, M_RA_IMM, 0, 0, 0,
		'hFFFFFFFF, 0, 'h3, 0, 'hFFFFFFF7, 'hFFFFFFF7, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_BST, M_RB_IMM, 0, 0, 0,
		0, 0, 'd31, 0, 'h80000000, 'h80000000, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_COPYB, M_RA_RB, 0, 0, 0,
		0, 'h12345678, 0, 0, 'h12345678, 'h12345678, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_COPYA, M_RA_IMM, 0, 0, 0,
		'hCAFE0000, 0, 0, 0, 'hCAFE0000, 'hCAFE0000, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_MOVHI, M_RA_IMM, 0, 0, 0,
		'hABCD0000, 0, 'h11234, 0, 'hABCD1234, 'hABCD1234, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_PC_IMM, F_CALL, 0, 0,
		0, 0, 'h40, 'h100, 'h140, 'h100, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_RB, F_RND, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_XOR, M_RA_RB, F_RND, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_SUB, M_RA_RB, F_RND, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

	// ********************
	// Flags and branches
	// ********************
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_RB, F_CRY, 0, 0,
		'hFFFFFFFF, 'h2, 0, 0, 'h1, 'h1, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADDC, M_RA_RB, 0, 0, 0, 'h1, 'h1, 0, 0, 'h3, 'h3, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_SUBC, M_RA_RB, 0, 0, 0, 'h10, 'h3, 0, 0, 'hC, 'hC, 0, 0, 0, 0);
	// 5 - 9 sets N and C, clears Z and O
	add_row(exec_pkg::ALU_OPC_CMP, M_RA_RB, F_FLG | F_CRY, 0, exec_pkg::CR_PSR,
		'h5, 'h9, 0, 0, 'hFFFFFFFC, 'hFFFFFFFC, 0, 0, 1, 'h0A);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_NE, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_EQ, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_LT, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_GT, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_LTS, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_GTES, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_B, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_CMP, M_RA_RB, F_FLG | F_CRY, 0, exec_pkg::CR_PSR,
		'h7, 'h7, 0, 0, 0, 0, 0, 0, 1, 'h01);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_EQ, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_LTE, 0,
		0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_GTS, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

	// ********************
	// Memory
	// ********************
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_ST, 0, 0,
		'h1000, 'hDEADBEEF, 'h24, 0, 'h1024, 'h24, 0, 1, 0, 0);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_LD, 0, 0,
		'h2000, 'h11111111, 'h8, 0, 'h2008, 'h2008, 0, 0, 0, 0);

	// ********************
	// Control registers and exceptions
	// ********************
	add_row(exec_pkg::ALU_OPC_COPYA, M_RA_IMM, F_WCR, 0, exec_pkg::CR_VECTOR,
		'h1040, 0, 0, 0, 'h1040, 'h1040, 0, 0, 1, 'h1040);
	add_row(exec_pkg::ALU_OPC_GCR, M_RA_IMM, 0, 0, exec_pkg::CR_VECTOR,
		0, 0, 0, 0, 'h1040, 'h1040, 0, 0, 1, 'h1040);
	add_row(exec_pkg::ALU_OPC_COPYA, M_RA_IMM, F_WCR | F_DBG, 0, exec_pkg::CR_VECTOR,
		'h2000, 0, 'h3000, 0, 'h2000, 'h2000, 0, 0, 1, 'h3000);
	add_row(exec_pkg::ALU_OPC_COPYA, M_RA_IMM, F_WCR, 0, exec_pkg::CR_PSR,
		'h13, 0, 0, 0, 'h13, 'h13, 0, 0, 1, 'h13);
	add_row(exec_pkg::ALU_OPC_SWI, M_RA_IMM, F_SWI | F_BR, 0, exec_pkg::CR_SAVED_PSR,
		0, 0, 0, 0, 'h3008, 'h3008, 1, 0, 1, 'h13);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_EXC, 0, exec_pkg::CR_FAULT,
		0, 0, 0, 'h500, 0, 0, 0, 0, 1, 'h500);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, 0, 0, exec_pkg::CR_PSR,
		0, 0, 0, 0, 0, 0, 0, 0, 1, 'h03);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_ABT, 0, exec_pkg::CR_DATA_FAULT,
		0, 0, 0, 0, 0, 0, 0, 0, 1, 'h2008);
	add_row(exec_pkg::ALU_OPC_RFE, M_RA_IMM, F_RFE | F_BR, 0, exec_pkg::CR_PSR,
		0, 0, 0, 0, 'h500, 'h500, 1, 0, 1, 'h13);
	add_row(exec_pkg::ALU_OPC_ADD, M_RA_IMM, F_BR, exec_pkg::BRANCH_CC_EQ, exec_pkg::CR_PSR,
		0, 0, 0, 0, 0, 0, 1, 0, 1, 'h13);
endtask

`endif

//--- dv/tb_exec_stage.sv
module tb_exec_stage;

	localparam int CLK_HALF = 2;
	localparam int RST_CYCLES = 3;
	localparam int RST_TIMEOUT = 20;
	localparam int SEED = 51;

	// Operand select: {op2_rb, op1 source}, op1 source 0=ra 1=rb 2=pc_plus_4
	localparam logic [2:0] M_RA_IMM = 3'b000;
	localparam logic [2:0] M_RB_IMM = 3'b001;
	localparam logic [2:0] M_PC_IMM = 3'b010;
	localparam logic [2:0] M_RA_RB = 3'b100;
	localparam logic [2:0] M_RB_RB = 3'b101;

	// Control strobes of a row
	localparam logic [12:0] F_FLG = 13'h0001;
	localparam logic [12:0] F_CRY = 13'h0002;
	localparam logic [12:0] F_CALL = 13'h0004;
	localparam logic [12:0] F_LD = 13'h0008;
	localparam logic [12:0] F_ST = 13'h0010;
	localparam logic [12:0] F_BR = 13'h0020;
	localparam logic [12:0] F_WCR = 13'h0040;
	localparam logic [12:0] F_SWI = 13'h0080;
	localparam logic [12:0] F_RFE = 13'h0100;
	localparam logic [12:0] F_EXC = 13'h0200;
	localparam logic [12:0] F_ABT = 13'h0400;
	localparam logic [12:0] F_DBG = 13'h0800; // Debug write of imm
	localparam logic [12:0] F_RND = 13'h1000; // Random ra and rb

	// Access width on memory rows, and a different one everywhere else
	localparam exec_pkg::mem_width_t W_MEM = 2'b10;
	localparam exec_pkg::mem_width_t W_OTHER = 2'b01;

	typedef struct {
		exec_pkg::alu_opc_t opc;
		logic [2:0] mode;
		logic [12:0] ctl;
		exec_pkg::branch_cc_t cc;
		exec_pkg::cr_sel_t cr;
		exec_pkg::word_t ra;
		exec_pkg::word_t rb;
		exec_pkg::word_t imm;
		exec_pkg::word_t pc4;
		exec_pkg::word_t e_alu;
		exec_pkg::word_t e_wr;
		logic e_taken;
		logic e_wren;
		logic chk;
		exec_pkg::word_t e_dbg;
	} vec_t;

	logic clk = 1'b0;
	logic rst;
	exec_pkg::word_t i_ra, i_rb, i_imm32, i_pc_plus_4, i_irq_fault_address, i_dbg_cr_wr_val;
	exec_pkg::rd_sel_t i_rd_sel;
	exec_pkg::alu_opc_t i_alu_opc;
	exec_pkg::mem_width_t i_mem_width;
	exec_pkg::branch_cc_t i_branch_cc;
	exec_pkg::instr_class_t i_instr_class;
	exec_pkg::cr_sel_t i_cr_sel, i_dbg_cr_sel;
	logic i_update_rd, i_alu_op1_ra, i_alu_op1_rb, i_alu_op2_rb, i_mem_load, i_mem_store;
	logic i_is_call, i_update_carry, i_update_flags, i_write_cr, i_is_swi, i_is_rfe;
	logic i_data_abort, i_exception_start, i_irq_start, i_valid, i_dbg_cr_wr_en;
	logic o_branch_taken, o_mem_load, o_mem_store, o_wr_result, o_stall_clear;
	logic o_mem_wr_en, o_valid, o_irqs_enabled;
	exec_pkg::word_t o_alu_out, o_wr_val, o_mar, o_mdr, o_dbg_cr_val;
	exec_pkg::mem_width_t o_mem_width;
	exec_pkg::rd_sel_t o_rd_sel;
	exec_pkg::vector_base_t o_vector_base;

	vec_t vectors[$];
	exec_pkg::word_t exp_mar = '0;
	exec_pkg::word_t exp_mdr = '0;
	exec_pkg::mem_width_t exp_width = '0;
	logic row_failed;
	int pass_rows = 0;
	int fail_rows = 0;

	always #(CLK_HALF) clk = ~clk;

	exec_stage i_exec_stage (.*);

	// Reference results for the random rows
	function automatic exec_pkg::word_t expected_alu(exec_pkg::alu_opc_t opc,
		exec_pkg::word_t a, exec_pkg::word_t b);
		case (opc)
		exec_pkg::ALU_OPC_ADD: return a + b;
		exec_pkg::ALU_OPC_SUB: return a - b;
		exec_pkg::ALU_OPC_XOR: return a ^ b;
		default: return '0;
		endcase
	endfunction

	task automatic add_row(input exec_pkg::alu_opc_t opc, input logic [2:0] mode,
		input logic [12:0] ctl, input exec_pkg::branch_cc_t cc, input exec_pkg::cr_sel_t cr,
		input exec_pkg::word_t ra, input exec_pkg::word_t rb, input exec_pkg::word_t imm,
		input exec_pkg::word_t pc4, input exec_pkg::word_t e_alu, input exec_pkg::word_t e_wr,
		input logic e_taken, input logic e_wren, input logic chk, input exec_pkg::word_t e_dbg);
		vec_t v;
		v = '{opc, mode, ctl, cc, cr, ra, rb, imm, pc4, e_alu, e_wr, e_taken, e_wren, chk, e_dbg};
		if (|(ctl & F_RND)) begin
			v.ra = $urandom;
			v.rb = $urandom;
			v.e_alu = expected_alu(opc, v.ra, v.rb);
			v.e_wr = v.e_alu;
		end
		vectors.push_back(v);
	endtask

	`include "exec_vectors.svh"

	task automatic drive_idle();
		{i_ra, i_rb, i_imm32, i_pc_plus_4, i_irq_fault_address, i_dbg_cr_wr_val} = '0;
		{i_rd_sel, i_alu_opc, i_mem_width, i_branch_cc, i_instr_class} = '0;
		{i_cr_sel, i_dbg_cr_sel} = '0;
		{i_update_rd, i_alu_op1_ra, i_alu_op1_rb, i_alu_op2_rb, i_mem_load, i_mem_store} = '0;
		{i_is_call, i_update_carry, i_update_flags, i_write_cr, i_is_swi, i_is_rfe} = '0;
		{i_data_abort, i_exception_start, i_irq_start, i_valid, i_dbg_cr_wr_en} = '0;
	endtask

	task automatic drive_row(input vec_t v);
		drive_idle();
		i_ra = v.ra;
		i_rb = v.rb;
		i_imm32 = v.imm;
		i_pc_plus_4 = v.pc4;
		i_alu_opc = v.opc;
		i_alu_op1_ra = (v.mode[1:0] == 2'd0);
		i_alu_op1_rb = (v.mode[1:0] == 2'd1);
		i_alu_op2_rb = v.mode[2];
		i_rd_sel = v.opc[3:0];
		i_update_rd = !(|(v.ctl & F_ST)); // Stores write no register
		i_mem_width = |(v.ctl & (F_LD | F_ST)) ? W_MEM : W_OTHER;
		i_update_flags = |(v.ctl & F_FLG);
		i_update_carry = |(v.ctl & F_CRY);
		i_is_call = |(v.ctl & F_CALL);
		i_mem_load = |(v.ctl & F_LD);
		i_mem_store = |(v.ctl & F_ST);
		i_instr_class = |(v.ctl & F_BR) ? exec_pkg::CLASS_BRANCH : 2'b00;
		i_branch_cc = v.cc;
		i_write_cr = |(v.ctl & F_WCR);
		i_is_swi = |(v.ctl & F_SWI);
		i_is_rfe = |(v.ctl & F_RFE);
		i_exception_start = |(v.ctl & F_EXC);
		i_data_abort = |(v.ctl & F_ABT);
		i_cr_sel = v.cr;
		i_dbg_cr_sel = v.cr;
		i_dbg_cr_wr_val = v.imm;
		i_dbg_cr_wr_en = |(v.ctl & F_DBG);
		i_valid = 1'b1;
	endtask

	task automatic check_word(input string name, input exec_pkg::word_t got,
		input exec_pkg::word_t exp);
		assert (got === exp)
		else begin
			$display("FAILED %s got=%h exp=%h", name, got, exp);
			row_failed = 1'b1;
		end
	endtask

	task automatic check_row(input int idx, input vec_t v);
		row_failed = 1'b0;
		if (|(v.ctl & (F_LD | F_ST))) begin
			exp_mar = v.e_alu; // Effective address
			exp_width = W_MEM;
		end
		if (|(v.ctl & F_ST))
			exp_mdr = v.rb;
		check_word("o_alu_out", o_alu_out, v.e_alu);
		check_word("o_wr_val", o_wr_val, v.e_wr);
		check_word("o_branch_taken", 32'(o_branch_taken), 32'(v.e_taken));
		check_word("o_stall_clear", 32'(o_stall_clear), 32'(|(v.ctl & F_BR)));
		check_word("o_mem_wr_en", 32'(o_mem_wr_en), 32'(v.e_wren));
		check_word("o_mem_load", 32'(o_mem_load), 32'(|(v.ctl & F_LD)));
		check_word("o_mem_store", 32'(o_mem_store), 32'(|(v.ctl & F_ST)));
		check_word("o_wr_result", 32'(o_wr_result), 32'(!(|(v.ctl & F_ST))));
		check_word("o_rd_sel", 32'(o_rd_sel), 32'(v.opc[3:0]));
		check_word("o_valid", 32'(o_valid), 32'd1);
		check_word("o_mar", o_mar, exp_mar);
		check_word("o_mem_width", 32'(o_mem_width), 32'(exp_width));
		check_word("o_mdr", o_mdr, exp_mdr);
		if (v.chk) begin
			check_word("o_dbg_cr_val", o_dbg_cr_val, v.e_dbg);
			if (v.cr == exec_pkg::CR_VECTOR)
				check_word("o_vector_base", 32'(o_vector_base), 32'(v.e_dbg[31:6]));
			if (v.cr == exec_pkg::CR_PSR)
				check_word("o_irqs_enabled", 32'(o_irqs_enabled), 32'(v.e_dbg[4]));
		end
		if (row_failed)
			fail_rows++;
		else
			pass_rows++;
		$display("row %0d %s", idx, row_failed ? "error" : "ok");
	endtask

	// ********************
	// Reset check
	// ********************
	task automatic check_reset();
		row_failed = 1'b0;
		check_word("o_ctrl", 32'({o_branch_taken, o_stall_clear, o_wr_result, o_mem_load,
			o_mem_store, o_mem_wr_en, o_valid, o_irqs_enabled}), 32'd0);
		check_word("o_vector_base", 32'(o_vector_base), 32'd0);
		for (int s = 0; s < exec_pkg::NUM_CR; s++) begin
			i_dbg_cr_sel = exec_pkg::cr_sel_t'(s);
			#1;
			check_word("o_dbg_cr_val", o_dbg_cr_val, 32'd0);
		end
		if (row_failed)
			fail_rows++;
		else
			pass_rows++;
		$display("reset %s", row_failed ? "error" : "ok");
	endtask

	initial begin
		int waited;
		void'($urandom(SEED));
		drive_idle();
		rst = 1'b1;
		load_vectors();
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;

		// Reset state visible on the outputs
		waited = 0;
		while (o_valid !== 1'b0 && waited < RST_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (o_valid !== 1'b0) begin
			$display("o_valid did not settle low after reset within %0d cycles", RST_TIMEOUT);
			fail_rows++;
		end else begin
			check_reset();
			@(posedge clk);
			#1 drive_row(vectors[0]);
			for (int i = 0; i < vectors.size(); i++) begin
				@(posedge clk);
				#1 check_row(i, vectors[i]);
				if (i + 1 < vectors.size())
					drive_row(vectors[i + 1]);
				else
					drive_idle();
			end
		end

		$display("%0d checks run, %0d passed, %0d failed", pass_rows + fail_rows,
			pass_rows, fail_rows);
		if (fail_rows == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+dv
design/exec_pkg.sv
design/exec_alu.sv
design/exec_ctrl_regs.sv
design/exec_stage.sv
dv/tb_exec_stage.sv
